// ==== pkt_pkg.sv ====
// Each link word holds two ASCII characters with the first one in the upper byte
package pkt_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths and counts
   //////////////////////////////////////////////////////////////////////
   localparam int LINK_NBIT     = 16;
   localparam int CHAR_NBIT     = LINK_NBIT / 2;
   localparam int TX_ADDR_NBIT  = 4;
   localparam int IO_UNIT_NBIT  = 8;
   localparam int IO_BANK_NUM   = 3;
   localparam int IO_BANK_NBIT  = 2;
   localparam int IO_DATA_NUM   = 3;
   localparam int MSG_LEN_NBIT  = 4;
   // Mask, direction and data bytes of one bank
   localparam int MSG_DATA_NBIT = IO_DATA_NUM * IO_UNIT_NBIT;

   //////////////////////////////////////////////////////////////////////
   // Message words
   //////////////////////////////////////////////////////////////////////
   localparam logic [LINK_NBIT-1:0] MSG_HEAD = "##";
   // Line feed and carriage return
   localparam logic [CHAR_NBIT-1:0] MSG_END_N = 8'h0A;
   localparam logic [CHAR_NBIT-1:0] MSG_END_R = 8'h0D;

   localparam logic [LINK_NBIT-1:0] MSG_TYPE_HANDSHAKE = "00";
   localparam logic [LINK_NBIT-1:0] MSG_TYPE_IOCTRL    = "02";

   localparam logic [LINK_NBIT-1:0] MSG_MODE_SETDATA = "01";
   localparam logic [LINK_NBIT-1:0] MSG_MODE_EXEDATA = "02";
   localparam logic [LINK_NBIT-1:0] MSG_MODE_SEXDATA = "03";

   localparam logic [LINK_NBIT-1:0] MSG_PASS = "PS";
   localparam logic [LINK_NBIT-1:0] MSG_FAIL = "FL";

   // Response codes
   localparam logic [LINK_NBIT-1:0] RESP_CODE_00 = "00";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_01 = "01";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_02 = "02";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_03 = "03";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_11 = "11";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_12 = "12";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_13 = "13";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_21 = "21";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_22 = "22";
   localparam logic [LINK_NBIT-1:0] RESP_CODE_23 = "23";

   // Carriage return first, then line feed
   localparam logic [LINK_NBIT-1:0] RESP_END = {MSG_END_R, MSG_END_N};

   //////////////////////////////////////////////////////////////////////
   // Hex conversion
   //////////////////////////////////////////////////////////////////////

   // Result is {error, nibble}, upper and lower case letters accepted
   function automatic logic [4:0] hex_char_to_nibble(input logic [CHAR_NBIT-1:0] c);
      if (c >= "0" && c <= "9") begin
         return {1'b0, c[3:0]};
      end else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) begin
         // Letters sit at 0x41 and 0x61 so the low nibble plus 9 gives the value
         return {1'b0, c[3:0] + 4'd9};
      end else begin
         return 5'b10000;
      end
   endfunction

   function automatic logic [CHAR_NBIT-1:0] nibble_to_hex_char(input logic [3:0] n);
      if (n < 4'd10) begin
         return {4'h3, n};
      end else begin
         return {4'h4, n - 4'd9};
      end
   endfunction

endpackage

// ==== msg_parser.sv ====
// i_rx_sop may come with the head word or before it, and i_rx_eop with or after the end word
`timescale 1ns/1ps
module msg_parser (
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_rx_vd,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_rx_data,
   input  logic                                i_rx_sop,
   input  logic                                i_rx_eop,
   output logic                                o_msg_done,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_msg_type,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_msg_mode,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_msg_chaddr,
   output logic [pkt_pkg::IO_BANK_NBIT-1:0]    o_msg_bank,
   output logic                                o_msg_err,
   output logic [pkt_pkg::MSG_LEN_NBIT-1:0]    o_msg_len,
   output logic [pkt_pkg::MSG_DATA_NBIT-1:0]   o_msg_data
);
   import pkt_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HEAD,
      ST_TYPE,
      ST_MODE,
      ST_CHADDR,
      ST_DATA,
      ST_END
   } rx_state_t;

   rx_state_t            state;
   logic                 is_end;
   logic [4:0]           hi_nib;
   logic [4:0]           lo_nib;
   logic [CHAR_NBIT-1:0] rx_byte;
   logic                 rx_bad;

   // End word is recognised by its second character alone
   assign is_end  = (i_rx_data[CHAR_NBIT-1:0] == MSG_END_N) ||
                    (i_rx_data[CHAR_NBIT-1:0] == MSG_END_R);

   assign hi_nib  = hex_char_to_nibble(i_rx_data[LINK_NBIT-1:CHAR_NBIT]);
   assign lo_nib  = hex_char_to_nibble(i_rx_data[CHAR_NBIT-1:0]);
   assign rx_byte = {hi_nib[3:0], lo_nib[3:0]};
   assign rx_bad  = hi_nib[4] | lo_nib[4];

   //////////////////////////////////////////////////////////////////////
   // Receive FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state      <= ST_IDLE;
         o_msg_done <= 1'b0;
      end else begin
         o_msg_done <= 1'b0;
         if (i_rx_sop) begin
            state <= (i_rx_vd && i_rx_data == MSG_HEAD) ? ST_TYPE : ST_HEAD;
         end else if (i_rx_eop && state >= ST_MODE) begin
            // Message closes once the type is known
            o_msg_done <= 1'b1;
            state      <= ST_IDLE;
         end else if (i_rx_vd) begin
            case (state)
               ST_HEAD:   state <= (i_rx_data == MSG_HEAD) ? ST_TYPE : ST_HEAD;
               ST_TYPE:   state <= ST_MODE;
               ST_MODE:   state <= is_end ? ST_END : ST_CHADDR;
               ST_CHADDR: state <= is_end ? ST_END : ST_DATA;
               ST_DATA:   state <= is_end ? ST_END : ST_DATA;
               default:   state <= state;
            endcase
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Field capture
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_rx_vd && !i_rx_sop) begin
         case (state)
            ST_TYPE: begin
               // Fields of the previous message stay valid up to here
               o_msg_type   <= i_rx_data;
               o_msg_mode   <= '0;
               o_msg_chaddr <= '0;
               o_msg_bank   <= '0;
               o_msg_err    <= 1'b0;
               o_msg_len    <= '0;
               o_msg_data   <= '0;
            end
            ST_MODE: begin
               o_msg_mode <= is_end ? '0 : i_rx_data;
            end
            ST_CHADDR: begin
               if (!is_end) begin
                  o_msg_chaddr <= i_rx_data;
                  o_msg_bank   <= rx_byte[IO_BANK_NBIT-1:0];
                  o_msg_err    <= rx_bad;
               end
            end
            ST_DATA: begin
               if (!is_end) begin
                  o_msg_data <= {o_msg_data[MSG_DATA_NBIT-CHAR_NBIT-1:0], rx_byte};
                  // Saturates so a long message never looks like length 0
                  o_msg_len  <= o_msg_len + (o_msg_len != '1);
                  o_msg_err  <= o_msg_err | rx_bad;
               end
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// ==== io_ctrl_exec.sv ====
// Bank index 3 is out of range and updates nothing, and the input pins are sampled on o_msg_done
`timescale 1ns/1ps
module io_ctrl_exec (
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_msg_done,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_msg_type,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_msg_mode,
   input  logic [pkt_pkg::IO_BANK_NBIT-1:0]    i_msg_bank,
   input  logic                                i_msg_err,
   input  logic [pkt_pkg::MSG_LEN_NBIT-1:0]    i_msg_len,
   input  logic [pkt_pkg::MSG_DATA_NBIT-1:0]   i_msg_data,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_p1_io_db,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_p2_io_db,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_p3_io_db,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p1_io_dir,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p1_io_db,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p2_io_dir,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p2_io_db,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p3_io_dir,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p3_io_db,
   output logic                                o_resp_start,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_resp_type,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_resp_pf,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_resp_code,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_bank_mask,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_bank_dir,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_bank_data
);
   import pkt_pkg::*;

   // Stored settings and driven outputs per bank, direction 1 is output
   logic [IO_UNIT_NBIT-1:0] mask_q  [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] dir_q   [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] data_q  [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] out_dir [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] out_db  [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] pin_db  [IO_BANK_NUM];
   logic [IO_BANK_NBIT-1:0] resp_bank;

   logic                    is_hs, is_io, bank_ok, resp_ok, len_ok;
   logic                    do_set, do_exe;
   logic [LINK_NBIT-1:0]    pf_d, code_d;
   logic [IO_UNIT_NBIT-1:0] cur_mask, cur_dir, cur_data, cur_pin;
   logic [IO_UNIT_NBIT-1:0] msg_mask, msg_dir, msg_db;
   logic [IO_UNIT_NBIT-1:0] new_dir, new_data;

   assign pin_db[0]   = i_p1_io_db;
   assign pin_db[1]   = i_p2_io_db;
   assign pin_db[2]   = i_p3_io_db;
   assign o_p1_io_dir = out_dir[0];
   assign o_p1_io_db  = out_db[0];
   assign o_p2_io_dir = out_dir[1];
   assign o_p2_io_db  = out_db[1];
   assign o_p3_io_dir = out_dir[2];
   assign o_p3_io_db  = out_db[2];

   assign is_hs   = (i_msg_type == MSG_TYPE_HANDSHAKE);
   assign is_io   = (i_msg_type == MSG_TYPE_IOCTRL);
   assign bank_ok = (i_msg_bank < IO_BANK_NUM);
   assign len_ok  = (i_msg_len == IO_DATA_NUM);

   assign cur_mask = bank_ok ? mask_q[i_msg_bank] : '0;
   assign cur_dir  = bank_ok ? dir_q[i_msg_bank]  : '0;
   assign cur_data = bank_ok ? data_q[i_msg_bank] : '0;
   assign cur_pin  = bank_ok ? pin_db[i_msg_bank] : '0;

   //////////////////////////////////////////////////////////////////////
   // Masked merge
   //////////////////////////////////////////////////////////////////////
   assign msg_mask = i_msg_data[3*IO_UNIT_NBIT-1 -: IO_UNIT_NBIT];
   assign msg_dir  = i_msg_data[2*IO_UNIT_NBIT-1 -: IO_UNIT_NBIT];
   assign msg_db   = i_msg_data[IO_UNIT_NBIT-1:0];

   // Masked bits keep their state, input bits take the pin level
   assign new_dir  = (msg_mask & cur_dir) | (~msg_mask & msg_dir);
   assign new_data = (msg_mask & cur_data) |
                     (~msg_mask & ((new_dir & msg_db) | (~new_dir & cur_pin)));

   // Pass or fail code, length is checked before bad characters
   always_comb begin
      do_set = 1'b0;
      do_exe = 1'b0;
      code_d = RESP_CODE_00;
      if (is_hs) begin
         code_d = RESP_CODE_01;
      end else begin
         case (i_msg_mode)
            MSG_MODE_SETDATA: begin
               code_d = !len_ok ? RESP_CODE_02 : (i_msg_err ? RESP_CODE_03 : RESP_CODE_01);
               do_set = len_ok && !i_msg_err;
            end
            MSG_MODE_EXEDATA: begin
               // A bad channel character is reported as 13
               code_d = (i_msg_len != '0) ? RESP_CODE_12 :
                        (i_msg_err ? RESP_CODE_13 : RESP_CODE_11);
               do_exe = (i_msg_len == '0) && !i_msg_err;
            end
            MSG_MODE_SEXDATA: begin
               code_d = !len_ok ? RESP_CODE_22 : (i_msg_err ? RESP_CODE_23 : RESP_CODE_21);
               do_set = len_ok && !i_msg_err;
               do_exe = len_ok && !i_msg_err;
            end
            default: begin
            end
         endcase
      end
      pf_d = (is_hs || do_set || do_exe) ? MSG_PASS : MSG_FAIL;
   end

   //////////////////////////////////////////////////////////////////////
   // Bank registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int b = 0; b < IO_BANK_NUM; b++) begin
            mask_q[b]  <= '0;
            dir_q[b]   <= '0;
            data_q[b]  <= '0;
            out_dir[b] <= '0;
            out_db[b]  <= '0;
         end
         o_resp_start <= 1'b0;
      end else begin
         // Unknown types get no response
         o_resp_start <= i_msg_done && (is_hs || is_io);
         if (i_msg_done && is_io && bank_ok) begin
            if (do_set) begin
               mask_q[i_msg_bank] <= msg_mask;
               dir_q[i_msg_bank]  <= new_dir;
               data_q[i_msg_bank] <= new_data;
            end
            if (do_exe) begin
               out_db[i_msg_bank]  <= do_set ? (new_data & ~msg_mask) : (cur_data & ~cur_mask);
               out_dir[i_msg_bank] <= do_set ? new_dir : cur_dir;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_msg_done) begin
         o_resp_type <= i_msg_type;
         o_resp_pf   <= pf_d;
         o_resp_code <= code_d;
         resp_bank   <= i_msg_bank;
      end
   end

   // Echo of the addressed bank after the update
   assign resp_ok     = (resp_bank < IO_BANK_NUM);
   assign o_bank_mask = resp_ok ? mask_q[resp_bank] : '0;
   assign o_bank_dir  = resp_ok ? dir_q[resp_bank]  : '0;
   assign o_bank_data = resp_ok ? data_q[resp_bank] : '0;

endmodule

// ==== resp_builder.sv ====
// No back-pressure, and an i_resp_start that arrives while a response is sent is dropped
`timescale 1ns/1ps
module resp_builder (
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_resp_start,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_resp_type,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_resp_pf,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_resp_code,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_msg_chaddr,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_bank_mask,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_bank_dir,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_bank_data,
   output logic                                o_tx_vd,
   output logic [pkt_pkg::TX_ADDR_NBIT-1:0]    o_tx_addr,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_tx_data,
   output logic                                o_tx_eop
);
   import pkt_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HEAD,
      ST_TYPE,
      ST_PF,
      ST_CODE,
      ST_CHADDR,
      ST_DATA,
      ST_END
   } tx_state_t;

   tx_state_t                state;
   logic [1:0]               data_cnt;
   logic [LINK_NBIT-1:0]     r_type, r_pf, r_code, r_chaddr;
   logic [MSG_DATA_NBIT-1:0] r_bytes;
   logic [LINK_NBIT-1:0]     hex_word;

   // Top byte of the shift register as two hex characters
   assign hex_word = {nibble_to_hex_char(r_bytes[MSG_DATA_NBIT-1 -: 4]),
                      nibble_to_hex_char(r_bytes[MSG_DATA_NBIT-5 -: 4])};

   //////////////////////////////////////////////////////////////////////
   // Transmit FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state     <= ST_IDLE;
         data_cnt  <= '0;
         o_tx_vd   <= 1'b0;
         o_tx_eop  <= 1'b0;
         o_tx_addr <= '0;
      end else begin
         o_tx_vd   <= (state != ST_IDLE);
         o_tx_eop  <= 1'b0;
         // Head word sits at address 0
         o_tx_addr <= (state == ST_IDLE || state == ST_HEAD) ? '0 : o_tx_addr + 1'b1;
         case (state)
            ST_IDLE: state <= i_resp_start ? ST_HEAD : ST_IDLE;
            ST_HEAD: state <= ST_TYPE;
            ST_TYPE: state <= ST_PF;
            ST_PF:   state <= ST_CODE;
            ST_CODE: begin
               // Handshake response stops at the code word
               if (r_type == MSG_TYPE_HANDSHAKE) begin
                  o_tx_eop <= 1'b1;
                  state    <= ST_IDLE;
               end else begin
                  state <= ST_CHADDR;
               end
            end
            ST_CHADDR: begin
               data_cnt <= 2'(IO_DATA_NUM - 1);
               state    <= ST_DATA;
            end
            ST_DATA: begin
               data_cnt <= data_cnt - 1'b1;
               state    <= (data_cnt == '0) ? ST_END : ST_DATA;
            end
            ST_END: begin
               o_tx_eop <= 1'b1;
               state    <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Word data
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      case (state)
         ST_IDLE: begin
            // Everything is captured so a following message cannot disturb it
            if (i_resp_start) begin
               r_type   <= i_resp_type;
               r_pf     <= i_resp_pf;
               r_code   <= i_resp_code;
               r_chaddr <= i_msg_chaddr;
               r_bytes  <= {i_bank_mask, i_bank_dir, i_bank_data};
            end
         end
         ST_HEAD:   o_tx_data <= MSG_HEAD;
         ST_TYPE:   o_tx_data <= r_type;
         ST_PF:     o_tx_data <= r_pf;
         ST_CODE:   o_tx_data <= r_code;
         ST_CHADDR: o_tx_data <= r_chaddr;
         ST_DATA: begin
            o_tx_data <= hex_word;
            r_bytes   <= r_bytes << CHAR_NBIT;
         end
         ST_END:    o_tx_data <= RESP_END;
         default: begin
         end
      endcase
   end

endmodule

// ==== pkt_decode.sv ====
// The host must not finish a new message while a response is still going out on o_tx_*
`timescale 1ns/1ps
module pkt_decode (
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_rx_vd,
   input  logic [pkt_pkg::LINK_NBIT-1:0]       i_rx_data,
   input  logic                                i_rx_sop,
   input  logic                                i_rx_eop,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_p1_io_db,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p1_io_dir,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p1_io_db,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_p2_io_db,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p2_io_dir,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p2_io_db,
   input  logic [pkt_pkg::IO_UNIT_NBIT-1:0]    i_p3_io_db,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p3_io_dir,
   output logic [pkt_pkg::IO_UNIT_NBIT-1:0]    o_p3_io_db,
   output logic                                o_tx_vd,
   output logic [pkt_pkg::TX_ADDR_NBIT-1:0]    o_tx_addr,
   output logic [pkt_pkg::LINK_NBIT-1:0]       o_tx_data,
   output logic                                o_tx_eop
);
   import pkt_pkg::*;

   // Parser to executer
   logic                     msg_done, msg_err;
   logic [LINK_NBIT-1:0]     msg_type, msg_mode, msg_chaddr;
   logic [IO_BANK_NBIT-1:0]  msg_bank;
   logic [MSG_LEN_NBIT-1:0]  msg_len;
   logic [MSG_DATA_NBIT-1:0] msg_data;

   // Executer to response builder
   logic                     resp_start;
   logic [LINK_NBIT-1:0]     resp_type, resp_pf, resp_code;
   logic [IO_UNIT_NBIT-1:0]  bank_mask, bank_dir, bank_data;

   msg_parser u_parser (
      .clk (clk), .i_rst_n (i_rst_n),
      .i_rx_vd (i_rx_vd), .i_rx_data (i_rx_data),
      .i_rx_sop (i_rx_sop), .i_rx_eop (i_rx_eop),
      .o_msg_done (msg_done), .o_msg_type (msg_type), .o_msg_mode (msg_mode),
      .o_msg_chaddr (msg_chaddr), .o_msg_bank (msg_bank), .o_msg_err (msg_err),
      .o_msg_len (msg_len), .o_msg_data (msg_data)
   );

   io_ctrl_exec u_exec (
      .clk (clk), .i_rst_n (i_rst_n),
      .i_msg_done (msg_done), .i_msg_type (msg_type), .i_msg_mode (msg_mode),
      .i_msg_bank (msg_bank), .i_msg_err (msg_err), .i_msg_len (msg_len),
      .i_msg_data (msg_data),
      .i_p1_io_db (i_p1_io_db), .i_p2_io_db (i_p2_io_db), .i_p3_io_db (i_p3_io_db),
      .o_p1_io_dir (o_p1_io_dir), .o_p1_io_db (o_p1_io_db),
      .o_p2_io_dir (o_p2_io_dir), .o_p2_io_db (o_p2_io_db),
      .o_p3_io_dir (o_p3_io_dir), .o_p3_io_db (o_p3_io_db),
      .o_resp_start (resp_start), .o_resp_type (resp_type),
      .o_resp_pf (resp_pf), .o_resp_code (resp_code),
      .o_bank_mask (bank_mask), .o_bank_dir (bank_dir), .o_bank_data (bank_data)
   );

   resp_builder u_builder (
      .clk (clk), .i_rst_n (i_rst_n),
      .i_resp_start (resp_start), .i_resp_type (resp_type),
      .i_resp_pf (resp_pf), .i_resp_code (resp_code), .i_msg_chaddr (msg_chaddr),
      .i_bank_mask (bank_mask), .i_bank_dir (bank_dir), .i_bank_data (bank_data),
      .o_tx_vd (o_tx_vd), .o_tx_addr (o_tx_addr),
      .o_tx_data (o_tx_data), .o_tx_eop (o_tx_eop)
   );

endmodule

// ==== pkt_decode_sva.sv ====
// Checks only the response port protocol and assumes o_tx_addr is reset to 0 while idle
`timescale 1ns/1ps
module pkt_decode_sva (
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                o_tx_vd,
   input  logic                                o_tx_eop,
   input  logic [pkt_pkg::TX_ADDR_NBIT-1:0]    o_tx_addr
);

   // End of packet marks a valid word only
   property eop_with_valid;
      @(posedge clk) disable iff (!i_rst_n)
         o_tx_eop |-> o_tx_vd;
   endproperty

   // Quiet port during reset and right after it
   property valid_low_after_reset;
      @(posedge clk)
         (!i_rst_n || $rose(i_rst_n)) |-> !o_tx_vd;
   endproperty

   // Next response starts again at address 0
   property addr_clear_after_eop;
      @(posedge clk) disable iff (!i_rst_n)
         o_tx_eop |=> (o_tx_addr == '0);
   endproperty

   a_eop_with_valid: assert property (eop_with_valid)
      else $error("o_tx_eop seen without o_tx_vd");
   a_valid_low_after_reset: assert property (valid_low_after_reset)
      else $error("o_tx_vd high during or right after reset");
   a_addr_clear_after_eop: assert property (addr_clear_after_eop)
      else $error("o_tx_addr not back to 0 after o_tx_eop");

endmodule

bind pkt_decode pkt_decode_sva i_sva (
   .clk       (clk),
   .i_rst_n   (i_rst_n),
   .o_tx_vd   (o_tx_vd),
   .o_tx_eop  (o_tx_eop),
   .o_tx_addr (o_tx_addr)
);

// ==== tb_pkt_decode.sv ====
// Directed tests only, one message in flight at a time, eop is sent together with the end word
`timescale 1ns/1ps
module tb_pkt_decode;
   import pkt_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_TESTS  = 5;
   localparam int RESP_WAIT  = 20;

   logic                     clk, i_rst_n, i_rx_vd, i_rx_sop, i_rx_eop;
   logic [LINK_NBIT-1:0]     i_rx_data;
   logic [IO_UNIT_NBIT-1:0]  i_p1_io_db, i_p2_io_db, i_p3_io_db;
   logic [IO_UNIT_NBIT-1:0]  o_p1_io_dir, o_p1_io_db, o_p2_io_dir, o_p2_io_db;
   logic [IO_UNIT_NBIT-1:0]  o_p3_io_dir, o_p3_io_db;
   logic                     o_tx_vd, o_tx_eop;
   logic [TX_ADDR_NBIT-1:0]  o_tx_addr;
   logic [LINK_NBIT-1:0]     o_tx_data;

   // Reference model of the banks and the pins driven by execute
   logic [IO_UNIT_NBIT-1:0]  m_mask [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0]  m_dir  [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0]  m_data [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0]  m_odir [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0]  m_odb  [IO_BANK_NUM];
   logic [LINK_NBIT-1:0]     msg[$];
   logic [LINK_NBIT-1:0]     resp[$];
   logic [LINK_NBIT-1:0]     exp_resp[$];
   logic [31:0]              lcg;
   int                       first_cyc, test_errors, errors, failed_tests;

   pkt_decode i_pkt_decode (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Watchdog sized from the test count
   initial begin
      #((NUM_TESTS * 60 + 8) * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("sim failed");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////
   function automatic logic [7:0] next_random();
      lcg = lcg * 32'd1103515245 + 32'd12345;
      return lcg[23:16];
   endfunction

   // ASCII digits and uppercase letters
   function automatic logic [7:0] hex_char(input logic [3:0] n);
      return (n < 4'd10) ? (8'h30 + 8'(n)) : (8'h41 + 8'(n) - 8'd10);
   endfunction

   function automatic logic [15:0] hex_byte(input logic [7:0] b);
      return {hex_char(b[7:4]), hex_char(b[3:0])};
   endfunction

   function automatic logic [7:0] pin_input(input int b);
      return (b == 0) ? i_p1_io_db : ((b == 1) ? i_p2_io_db : i_p3_io_db);
   endfunction

   task automatic randomize_pins();
      i_p1_io_db = next_random();
      i_p2_io_db = next_random();
      i_p3_io_db = next_random();
   endtask

   task automatic send_message();
      for (int i = 0; i < msg.size(); i++) begin
         @(negedge clk);
         i_rx_vd   = 1'b1;
         i_rx_data = msg[i];
         i_rx_sop  = (i == 0);
         i_rx_eop  = (i == msg.size() - 1);
      end
      // Edge that samples eop, then release the link
      @(posedge clk);
      @(negedge clk);
      i_rx_vd   = 1'b0;
      i_rx_sop  = 1'b0;
      i_rx_eop  = 1'b0;
      i_rx_data = '0;
   endtask

   // Cycle count is 0 on the falling edge after the eop edge
   task automatic collect_response(output bit got_eop);
      int n;
      resp.delete();
      first_cyc = 0;
      got_eop   = 1'b0;
      n         = 0;
      while (n <= RESP_WAIT && !got_eop) begin
         if (o_tx_vd) begin
            if (resp.size() == 0) begin
               first_cyc = n;
            end
            if (o_tx_addr != resp.size()) begin
               $display("MISMATCH o_tx_addr: got %h expected %h", o_tx_addr, resp.size());
               test_errors++;
            end
            resp.push_back(o_tx_data);
            got_eop = o_tx_eop;
         end
         if (!got_eop) begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic check_pins();
      logic [7:0] got_dir, got_db;
      for (int b = 0; b < IO_BANK_NUM; b++) begin
         got_dir = (b == 0) ? o_p1_io_dir : ((b == 1) ? o_p2_io_dir : o_p3_io_dir);
         got_db  = (b == 0) ? o_p1_io_db : ((b == 1) ? o_p2_io_db : o_p3_io_db);
         if (got_dir !== m_odir[b]) begin
            $display("MISMATCH o_p%0d_io_dir: got %h expected %h", b + 1, got_dir, m_odir[b]);
            test_errors++;
         end
         if (got_db !== m_odb[b]) begin
            $display("MISMATCH o_p%0d_io_db: got %h expected %h", b + 1, got_db, m_odb[b]);
            test_errors++;
         end
      end
   endtask

   task automatic run_message();
      bit got_eop;
      send_message();
      collect_response(got_eop);
      if (!got_eop) begin
         $display("No complete response within %0d cycles of the eop", RESP_WAIT);
         test_errors++;
      end else if (resp.size() != exp_resp.size()) begin
         $display("Response had %0d words but %0d were expected", resp.size(), exp_resp.size());
         test_errors++;
      end else begin
         for (int i = 0; i < resp.size(); i++) begin
            if (resp[i] !== exp_resp[i]) begin
               $display("MISMATCH o_tx_data[%0d]: got %h expected %h", i, resp[i], exp_resp[i]);
               test_errors++;
            end
         end
      end
      check_pins();
   endtask

   // Builds an I/O message, updates the model and runs the exchange
   task automatic io_exchange(input logic [15:0] mode, input int bank,
                              input logic [7:0] mask, input logic [7:0] dir,
                              input logic [7:0] db, input bit bad, input int len);
      logic [7:0]  fields [3];
      logic [7:0]  ndir, ndata, pin;
      logic [15:0] code, word;
      bit          set_ok, exe_ok;
      fields[0] = mask;
      fields[1] = dir;
      fields[2] = db;
      msg.delete();
      msg.push_back(MSG_HEAD);
      msg.push_back(MSG_TYPE_IOCTRL);
      msg.push_back(mode);
      msg.push_back(hex_byte(8'(bank)));
      for (int i = 0; i < len; i++) begin
         word = hex_byte(fields[i]);
         if (bad && i == len - 1) begin
            word[15:8] = "G";
         end
         msg.push_back(word);
      end
      msg.push_back({MSG_END_R, MSG_END_N});
      pin    = pin_input(bank);
      set_ok = 1'b0;
      exe_ok = 1'b0;
      if (mode == MSG_MODE_SETDATA) begin
         code   = (len != IO_DATA_NUM) ? RESP_CODE_02 : (bad ? RESP_CODE_03 : RESP_CODE_01);
         set_ok = (code == RESP_CODE_01);
      end else if (mode == MSG_MODE_EXEDATA) begin
         code   = (len != 0) ? RESP_CODE_12 : RESP_CODE_11;
         exe_ok = (code == RESP_CODE_11);
      end else if (mode == MSG_MODE_SEXDATA) begin
         code   = (len != IO_DATA_NUM) ? RESP_CODE_22 : (bad ? RESP_CODE_23 : RESP_CODE_21);
         set_ok = (code == RESP_CODE_21);
         exe_ok = set_ok;
      end else begin
         code = RESP_CODE_00;
      end
      // Bit by bit merge
      for (int k = 0; k < IO_UNIT_NBIT; k++) begin
         if (mask[k]) begin
            ndir[k]  = m_dir[bank][k];
            ndata[k] = m_data[bank][k];
         end else begin
            ndir[k]  = dir[k];
            ndata[k] = dir[k] ? db[k] : pin[k];
         end
      end
      if (set_ok) begin
         m_mask[bank] = mask;
         m_dir[bank]  = ndir;
         m_data[bank] = ndata;
      end
      if (exe_ok) begin
         m_odb[bank]  = m_data[bank] & ~m_mask[bank];
         m_odir[bank] = m_dir[bank];
      end
      exp_resp.delete();
      exp_resp.push_back(MSG_HEAD);
      exp_resp.push_back(MSG_TYPE_IOCTRL);
      exp_resp.push_back((set_ok || exe_ok) ? MSG_PASS : MSG_FAIL);
      exp_resp.push_back(code);
      exp_resp.push_back(hex_byte(8'(bank)));
      exp_resp.push_back(hex_byte(m_mask[bank]));
      exp_resp.push_back(hex_byte(m_dir[bank]));
      exp_resp.push_back(hex_byte(m_data[bank]));
      exp_resp.push_back({MSG_END_R, MSG_END_N});
      run_message();
   endtask

   task automatic report_test(input string name);
      if (test_errors == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: FAILED with %0d errors", name, test_errors);
         failed_tests++;
      end
      errors      += test_errors;
      test_errors  = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic handshake_reply();
      msg      = '{MSG_HEAD, MSG_TYPE_HANDSHAKE, {MSG_END_R, MSG_END_N}};
      exp_resp = '{MSG_HEAD, MSG_TYPE_HANDSHAKE, MSG_PASS, RESP_CODE_01};
      run_message();
      if (first_cyc != 3) begin
         $display("Head word came %0d cycles after the eop edge instead of 3", first_cyc);
         test_errors++;
      end
      report_test("handshake");
   endtask

   task automatic set_exe_bank2();
      randomize_pins();
      io_exchange(MSG_MODE_SEXDATA, 2, next_random(), next_random(), next_random(), 0, 3);
      report_test("set and execute bank 2");
   endtask

   task automatic set_then_execute();
      randomize_pins();
      io_exchange(MSG_MODE_SETDATA, 0, next_random(), next_random(), next_random(), 0, 3);
      io_exchange(MSG_MODE_EXEDATA, 0, 8'h00, 8'h00, 8'h00, 0, 0);
      report_test("set then execute bank 0");
   endtask

   task automatic bad_char_reject();
      randomize_pins();
      io_exchange(MSG_MODE_SEXDATA, 1, next_random(), next_random(), next_random(), 1, 3);
      report_test("bad data character");
   endtask

   task automatic fail_codes();
      io_exchange("07", 0, next_random(), next_random(), next_random(), 0, 3);
      io_exchange(MSG_MODE_SETDATA, 1, next_random(), next_random(), 8'h00, 0, 2);
      report_test("unknown mode and short set");
   endtask

   initial begin
      lcg          = 32'd61;
      errors       = 0;
      test_errors  = 0;
      failed_tests = 0;
      i_rst_n      = 1'b0;
      i_rx_vd      = 1'b0;
      i_rx_sop     = 1'b0;
      i_rx_eop     = 1'b0;
      i_rx_data    = '0;
      i_p1_io_db   = '0;
      i_p2_io_db   = '0;
      i_p3_io_db   = '0;
      for (int b = 0; b < IO_BANK_NUM; b++) begin
         m_mask[b] = '0;
         m_dir[b]  = '0;
         m_data[b] = '0;
         m_odir[b] = '0;
         m_odb[b]  = '0;
      end
      repeat (4) @(negedge clk);
      i_rst_n = 1'b1;
      handshake_reply();
      set_exe_bank2();
      set_then_execute();
      bad_char_reject();
      fail_codes();
      $display("Tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== pkt_decode.f ====
pkt_pkg.sv
msg_parser.sv
io_ctrl_exec.sv
resp_builder.sv
pkt_decode.sv
pkt_decode_sva.sv
tb_pkt_decode.sv
